//--- Makefile
# Verilator build and run for the Arkanoid video testbench

SIM = obj_dir/VarkVideoTb
SRCS = $(wildcard design/*.sv dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert --top-module arkVideoTb \
		-Mdir obj_dir -o VarkVideoTb -f files.f

sim.log: $(SIM)
	./$(SIM) | tee sim.log

run: sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/arkVideoPkg.sv
// Arkanoid video shared definitions
// Raster limits, sync and blank ranges, CPU memory map and common types
package arkVideoPkg;

	// ========================================
	// Raster counters
	// ========================================
	localparam logic [8:0] HStart    = 9'd128;	// H wraps back here
	localparam logic [8:0] VStart    = 9'd248;	// V wraps back here
	localparam logic [8:0] CountMax  = 9'd511;
	localparam logic [8:0] HsOn      = 9'd200;
	localparam logic [8:0] HsOff     = 9'd216;
	localparam logic [8:0] VsOn      = 9'd263;
	localparam logic [8:0] VsOff     = 9'd268;
	localparam logic [8:0] HBlankOn  = 9'd140;
	localparam logic [8:0] HBlankOff = 9'd256;
	localparam logic [8:0] VBlankOn  = 9'd240;
	localparam logic [8:0] VBlankOff = 9'd269;
	localparam logic [8:0] IrqLine   = 9'd248;	// Vblank interrupt point
	localparam logic [8:0] IrqCol    = 9'd128;

	// ========================================
	// CPU memory map
	// ========================================
	localparam logic [15:0] VramBase   = 16'hE000;
	localparam logic [15:0] VramTop    = 16'hEFFF;
	localparam logic [15:0] CtrlAddr   = 16'hD008;
	localparam logic [10:0] SpriteBase = 11'h400;	// VRAM word address

	typedef logic [8:0]  rasterCount;
	typedef logic [15:0] vramWord;
	typedef logic [14:0] gfxAddr;
	typedef logic [8:0]  palAddr;

	// One sprite line buffer entry
	typedef struct packed {
		logic [4:0] colour;
		logic [2:0] dot;	// Zero means transparent
	} linePixel;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} palEntry;

	// D008 bit layout, MSB first
	typedef struct packed {
		logic mcuReset;
		logic palBank;
		logic gfxBank;
		logic unknown4;
		logic coinLock;
		logic padSel;
		logic flipY;
		logic flipX;
	} ctrlBits;

endpackage

//--- design/arkVideoTop.sv
// Arkanoid video top level
// Raster timing, CPU VRAM port, sprite and tile fetch, bitplane shifters
// and pixel mixer tied together. Tile and palette ROMs sit outside
`timescale 1ns/1ps

module arkVideoTop #(
	parameter int NumPlanes = 3	// One shifter per tile ROM
) (
	input  logic                         CLK_6M,
	input  logic                         RESET,
	input  logic [15:0]                  cpuAddr,
	input  logic [7:0]                   cpuDataOut,
	input  logic                         cpuWrN,
	input  logic                         cpuIntAck,
	input  logic [NumPlanes*8-1:0]       gfxRomData,	// One byte per plane
	input  arkVideoPkg::palEntry         palRomData,
	output logic [7:0]                   cpuDataIn,
	output logic                         cpuIrq,
	output arkVideoPkg::gfxAddr          gfxRomAddr,
	output arkVideoPkg::palAddr          palRomAddr,
	output logic [7:0]                   vgaR,
	output logic [7:0]                   vgaG,
	output logic [7:0]                   vgaB,
	output logic                         vgaHs,
	output logic                         vgaVs,
	output logic                         vgaDe
);

	arkVideoPkg::rasterCount hCount;
	arkVideoPkg::rasterCount vCount;
	logic                    hs;
	logic                    vs;
	logic                    blank;
	logic                    spritePhase;	// H 128..255
	arkVideoPkg::vramWord    vramData;
	arkVideoPkg::ctrlBits    ctrl;
	logic [9:0]              spriteIndex;
	logic [3:0]              spriteRow;
	arkVideoPkg::linePixel   spritePixel;
	logic [NumPlanes-1:0]    planeLoad;
	logic [NumPlanes-1:0]    planeBits;	// Current dot from each plane
	logic [4:0]              bgColour;

	crtTiming i_crtTiming (
		.CLK_6M, .RESET, .hCount, .vCount, .hs, .vs, .blank, .spritePhase
	);

	cpuBusPort i_cpuBusPort (
		.CLK_6M, .RESET, .cpuAddr, .cpuDataOut, .cpuWrN, .cpuIntAck,
		.hCount, .vCount, .spritePhase, .cpuDataIn, .cpuIrq, .vramData, .ctrl
	);

	spriteFetch #(.NumPlanes(NumPlanes)) i_spriteFetch (
		.CLK_6M, .RESET, .hCount, .vCount, .spritePhase, .vramData, .planeBits,
		.spriteIndex, .spriteRow, .spritePixel
	);

	tileFetch #(.NumPlanes(NumPlanes)) i_tileFetch (
		.CLK_6M, .RESET, .hCount, .vCount, .spritePhase, .vramData,
		.spriteIndex, .spriteRow, .ctrl, .gfxRomAddr, .planeLoad, .bgColour
	);

	// ========================================
	// Bitplane shifters
	// ========================================
	for (genvar p = 0; p < NumPlanes; p++) begin : gPlane
		bitplaneShifter i_bitplaneShifter (
			.CLK_6M,
			.RESET,
			.planeLoad (planeLoad[p]),
			.planeByte (gfxRomData[p*8 +: 8]),
			.flipX     (ctrl.flipX),
			.pixelBit  (planeBits[p])
		);
	end

	pixelMixer #(.NumPlanes(NumPlanes)) i_pixelMixer (
		.CLK_6M, .RESET, .planeBits, .bgColour, .spritePixel, .ctrl, .palRomData,
		.hs, .vs, .blank, .palRomAddr, .vgaR, .vgaG, .vgaB, .vgaHs, .vgaVs, .vgaDe
	);

endmodule

//--- design/bitplaneShifter.sv
// Bitplane shifter
// Loads one tile ROM byte and sends one dot per clock
// MSB first normally, LSB first when flipped in X
`timescale 1ns/1ps

module bitplaneShifter (
	input  logic       CLK_6M,
	input  logic       RESET,
	input  logic       planeLoad,
	input  logic [7:0] planeByte,
	input  logic       flipX,
	output logic       pixelBit
);

	logic [7:0] shiftReg;

	always_ff @(posedge CLK_6M or negedge RESET) begin
		if (!RESET)
			shiftReg <= 8'd0;
		else if (planeLoad)
			shiftReg <= planeByte;
		else if (flipX)
			shiftReg <= {1'b0, shiftReg[7:1]};	// Toward LSB
		else
			shiftReg <= {shiftReg[6:0], 1'b0};
	end

	assign pixelBit = flipX ? shiftReg[0] : shiftReg[7];

endmodule

//--- design/cpuBusPort.sv
// CPU side of the video board
// Decodes the VRAM window and the D008 control register, shares VRAM
// between CPU and video fetch, and raises the vblank interrupt
// VRAM is 2K x 16 as two byte lanes, CPU address bit 0 picks the lane
`timescale 1ns/1ps

module cpuBusPort (
	input  logic                    CLK_6M,
	input  logic                    RESET,
	input  logic [15:0]             cpuAddr,
	input  logic [7:0]              cpuDataOut,
	input  logic                    cpuWrN,
	input  logic                    cpuIntAck,
	input  arkVideoPkg::rasterCount hCount,
	input  arkVideoPkg::rasterCount vCount,
	input  logic                    spritePhase,
	output logic [7:0]              cpuDataIn,
	output logic                    cpuIrq,
	output arkVideoPkg::vramWord    vramData,
	output arkVideoPkg::ctrlBits    ctrl
);

	logic        vramCs;
	logic        ctrlCs;
	logic [10:0] fetchAddr;
	logic [10:0] vramAddr;
	logic        loWe;
	logic        hiWe;
	logic [7:0]  loData;
	logic [7:0]  hiData;
	logic        laneSel;	// Address bit 0 of the last access
	logic        vramRead;

	assign vramCs = (cpuAddr >= arkVideoPkg::VramBase) && (cpuAddr <= arkVideoPkg::VramTop);
	assign ctrlCs = (cpuAddr == arkVideoPkg::CtrlAddr);

	// ========================================
	// VRAM address mux
	// ========================================
	// Sprite half reads table words 0x400..0x41F, active half the tile map
	assign fetchAddr = spritePhase ? (arkVideoPkg::SpriteBase + {6'd0, hCount[6:2]}) :
	                                 {1'b0, vCount[7:3], hCount[7:3]};
	assign vramAddr  = vramCs ? cpuAddr[11:1] : fetchAddr;	// CPU always wins

	assign loWe = vramCs && !cpuWrN && !cpuAddr[0];
	assign hiWe = vramCs && !cpuWrN && cpuAddr[0];

	dualPortRam #(.PayloadType(logic [7:0]), .AddrBits(11)) i_vramLo (
		.CLK_6M, .writeEn(loWe), .writeAddr(vramAddr), .writeData(cpuDataOut),
		.readAddr(vramAddr), .readData(loData)
	);

	dualPortRam #(.PayloadType(logic [7:0]), .AddrBits(11)) i_vramHi (
		.CLK_6M, .writeEn(hiWe), .writeAddr(vramAddr), .writeData(cpuDataOut),
		.readAddr(vramAddr), .readData(hiData)
	);

	assign vramData = {hiData, loData};
	assign cpuDataIn = vramRead ? (laneSel ? hiData : loData) : 8'hFF;	// Open bus reads FF

	// Control register, interrupt and read steering
	always_ff @(posedge CLK_6M or negedge RESET) begin
		if (!RESET) begin
			ctrl     <= arkVideoPkg::ctrlBits'(8'hFF);	// All set out of reset
			cpuIrq   <= 1'b0;
			laneSel  <= 1'b0;
			vramRead <= 1'b0;
		end else begin
			laneSel  <= cpuAddr[0];	// Matches RAM read latency
			vramRead <= vramCs;
			if (ctrlCs && !cpuWrN)
				ctrl <= arkVideoPkg::ctrlBits'(cpuDataOut);
			if (cpuIntAck)
				cpuIrq <= 1'b0;	// Ack beats a new set
			else if (hCount == arkVideoPkg::IrqCol && vCount == arkVideoPkg::IrqLine)
				cpuIrq <= 1'b1;
		end
	end

endmodule

//--- design/crtTiming.sv
// CRT raster timing
// H counts 128..511 (384 clocks), V counts 248..511 (264 lines)
// Sync pulses are active low, blank covers both retrace regions
`timescale 1ns/1ps

module crtTiming (
	input  logic                    CLK_6M,
	input  logic                    RESET,
	output arkVideoPkg::rasterCount hCount,
	output arkVideoPkg::rasterCount vCount,
	output logic                    hs,
	output logic                    vs,
	output logic                    blank,
	output logic                    spritePhase
);

	logic hBlank;
	logic vBlank;

	always_ff @(posedge CLK_6M or negedge RESET) begin
		if (!RESET) begin
			hCount <= arkVideoPkg::HStart;
			vCount <= arkVideoPkg::VStart;
		end else if (hCount == arkVideoPkg::CountMax) begin
			hCount <= arkVideoPkg::HStart;	// End of line
			if (vCount == arkVideoPkg::CountMax)
				vCount <= arkVideoPkg::VStart;	// End of frame
			else
				vCount <= vCount + 9'd1;
		end else begin
			hCount <= hCount + 9'd1;
		end
	end

	// ========================================
	// Decodes
	// ========================================
	assign hs = !(hCount >= arkVideoPkg::HsOn && hCount <= arkVideoPkg::HsOff);
	assign vs = !(vCount >= arkVideoPkg::VsOn && vCount <= arkVideoPkg::VsOff);

	assign hBlank = (hCount >= arkVideoPkg::HBlankOn) && (hCount <= arkVideoPkg::HBlankOff);
	assign vBlank = (vCount >= arkVideoPkg::VBlankOn) && (vCount <= arkVideoPkg::VBlankOff);
	assign blank  = hBlank || vBlank;

	// Bit 8 low means the sprite table half of the line
	assign spritePhase = !hCount[8];

endmodule

//--- design/dualPortRam.sv
// Simple dual port RAM
// One write port and one registered read port on the same clock
// Read during write of the same word returns the old contents
`timescale 1ns/1ps

module dualPortRam #(
	parameter type PayloadType = logic [7:0],
	parameter int  AddrBits    = 11
) (
	input  logic                CLK_6M,
	input  logic                writeEn,
	input  logic [AddrBits-1:0] writeAddr,
	input  PayloadType          writeData,
	input  logic [AddrBits-1:0] readAddr,
	output PayloadType          readData
);

	PayloadType mem [0:(1 << AddrBits) - 1];

	always_ff @(posedge CLK_6M) begin
		if (writeEn)
			mem[writeAddr] <= writeData;
		readData <= mem[readAddr];	// One cycle latency
	end

endmodule

//--- design/pixelMixer.sv
// Pixel mixer and video output
// Sprite dot wins over background, palette bank prefixes the colour
// RGB widened to 8 bits, zero while blanked, syncs delayed to match
`timescale 1ns/1ps

module pixelMixer #(
	parameter int NumPlanes = 3
) (
	input  logic                  CLK_6M,
	input  logic                  RESET,
	input  logic [NumPlanes-1:0]  planeBits,
	input  logic [4:0]            bgColour,
	input  arkVideoPkg::linePixel spritePixel,
	input  arkVideoPkg::ctrlBits  ctrl,
	input  arkVideoPkg::palEntry  palRomData,
	input  logic                  hs,
	input  logic                  vs,
	input  logic                  blank,
	output arkVideoPkg::palAddr   palRomAddr,
	output logic [7:0]            vgaR,
	output logic [7:0]            vgaG,
	output logic [7:0]            vgaB,
	output logic                  vgaHs,
	output logic                  vgaVs,
	output logic                  vgaDe
);

	localparam int PixelLatency = 3;	// Address reg, palette ROM, RGB reg

	logic                    spriteWins;
	logic [PixelLatency-1:0] hsPipe;
	logic [PixelLatency-1:0] vsPipe;
	logic [PixelLatency-1:0] dePipe;

	assign spriteWins = (spritePixel.dot != 3'd0);

	always_ff @(posedge CLK_6M) begin
		palRomAddr <= spriteWins ? {ctrl.palBank, spritePixel} :
		                           {ctrl.palBank, bgColour, planeBits};
	end

	always_ff @(posedge CLK_6M or negedge RESET) begin
		if (!RESET) begin
			hsPipe <= '1;	// Syncs idle high
			vsPipe <= '1;
			dePipe <= '0;
			vgaR   <= 8'd0;
			vgaG   <= 8'd0;
			vgaB   <= 8'd0;
		end else begin
			hsPipe <= {hsPipe[PixelLatency-2:0], hs};
			vsPipe <= {vsPipe[PixelLatency-2:0], vs};
			dePipe <= {dePipe[PixelLatency-2:0], !blank};
			// Enable entering the last stage gates the colour
			vgaR <= dePipe[PixelLatency-2] ? {palRomData.red, 4'h0} : 8'd0;
			vgaG <= dePipe[PixelLatency-2] ? {palRomData.green, 4'h0} : 8'd0;
			vgaB <= dePipe[PixelLatency-2] ? {palRomData.blue, 4'h0} : 8'd0;
		end
	end

	assign vgaHs = hsPipe[PixelLatency-1];
	assign vgaVs = vsPipe[PixelLatency-1];
	assign vgaDe = dePipe[PixelLatency-1];

endmodule

//--- design/spriteFetch.sv
// Sprite fetch and line buffer
// Each 8 clock slot of the sprite half reads one table entry from VRAM,
// adds its Y to the line and keeps it if the sum's high nibble is all ones
// Plane bits land in a 512 entry line buffer at X, which the active line
// reads back and clears behind itself
`timescale 1ns/1ps

module spriteFetch #(
	parameter int NumPlanes = 3
) (
	input  logic                    CLK_6M,
	input  logic                    RESET,
	input  arkVideoPkg::rasterCount hCount,
	input  arkVideoPkg::rasterCount vCount,
	input  logic                    spritePhase,
	input  arkVideoPkg::vramWord    vramData,
	input  logic [NumPlanes-1:0]    planeBits,
	output logic [9:0]              spriteIndex,
	output logic [3:0]              spriteRow,
	output arkVideoPkg::linePixel   spritePixel
);

	logic [2:0]            phase;
	arkVideoPkg::vramWord  xyTemp;	// Y in high byte, X in low byte
	arkVideoPkg::vramWord  icTemp;	// Index and colour word
	logic [7:0]            ySum;
	logic [7:0]            spriteX;
	logic [4:0]            spriteColour;
	logic                  spriteHit;
	logic                  loadNow;
	logic                  drawValid;
	logic [2:0]            pixCount;
	logic [7:0]            drawX;
	logic [4:0]            drawColour;
	logic [7:0]            readLow;
	logic                  bufWe;
	logic [8:0]            bufWAddr;
	arkVideoPkg::linePixel bufWData;

	assign phase = hCount[2:0];
	assign ySum  = xyTemp[15:8] + vCount[7:0];	// Two 4 bit adders on the board

	always_ff @(posedge CLK_6M) begin
		if (spritePhase) begin
			if (phase == 3'd1) xyTemp <= vramData;
			if (phase == 3'd5) icTemp <= vramData;
			if (phase == 3'd7) begin
				spriteX      <= xyTemp[7:0];
				spriteIndex  <= {icTemp[1:0], icTemp[15:8]};
				spriteColour <= icTemp[6:2];
				spriteRow    <= ySum[3:0];	// Row within the 16 line tile
			end
		end
		if (loadNow) begin
			drawX      <= spriteX;
			drawColour <= spriteColour;
		end
	end

	// ========================================
	// Draw control
	// ========================================
	// Pixels of a slot's sprite arrive one slot later, in step with the shifter load
	// The first slot of a line has nothing committed yet
	assign loadNow = spritePhase && (phase == 3'd2) && (hCount[6:3] != 4'd0);

	always_ff @(posedge CLK_6M or negedge RESET) begin
		if (!RESET) begin
			spriteHit <= 1'b0;
			drawValid <= 1'b0;
			pixCount  <= 3'd0;
		end else begin
			if (spritePhase && phase == 3'd7)
				spriteHit <= (ySum[7:4] == 4'hF);
			if (loadNow) begin
				drawValid <= spriteHit;
				pixCount  <= 3'd0;
			end else if (drawValid) begin
				pixCount <= pixCount + 3'd1;
				if (pixCount == 3'd7) drawValid <= 1'b0;	// Eight dots written
			end
		end
	end

	// Active line reads 3 ahead to meet the background shifter timing
	assign readLow = hCount[7:0] - 8'd3;

	assign bufWe    = drawValid ? (planeBits != '0) : !spritePhase;	// Keep earlier sprites under clear dots
	assign bufWAddr = drawValid ? {1'b0, drawX + {5'd0, pixCount}} : {1'b0, readLow - 8'd1};
	assign bufWData = drawValid ? arkVideoPkg::linePixel'({drawColour, planeBits}) : '0;

	dualPortRam #(.PayloadType(arkVideoPkg::linePixel), .AddrBits(9)) i_lineBuffer (
		.CLK_6M, .writeEn(bufWe), .writeAddr(bufWAddr), .writeData(bufWData),
		.readAddr({1'b0, readLow}), .readData(spritePixel)
	);

endmodule

//--- design/tileFetch.sv
// Tile ROM address generator
// Sprite half addresses {bank, sprite index, row}, active half addresses
// {bank, tile index, line bits}. Strobes the plane load when ROM data is due
// and carries the tile colour alongside
`timescale 1ns/1ps

module tileFetch #(
	parameter int NumPlanes = 3
) (
	input  logic                    CLK_6M,
	input  logic                    RESET,
	input  arkVideoPkg::rasterCount hCount,
	input  arkVideoPkg::rasterCount vCount,
	input  logic                    spritePhase,
	input  arkVideoPkg::vramWord    vramData,
	input  logic [9:0]              spriteIndex,
	input  logic [3:0]              spriteRow,
	input  arkVideoPkg::ctrlBits    ctrl,
	output arkVideoPkg::gfxAddr     gfxRomAddr,
	output logic [NumPlanes-1:0]    planeLoad,
	output logic [4:0]              bgColour
);

	logic [10:0] bgIndex;
	logic [2:0]  loadPhase;
	logic [4:0]  colourPipe;

	assign bgIndex   = {vramData[2:0], vramData[15:8]};
	assign loadPhase = spritePhase ? 3'd1 : 3'd2;	// Tile map word is one clock later

	always_ff @(posedge CLK_6M) begin
		gfxRomAddr <= spritePhase ? {ctrl.gfxBank, spriteIndex, spriteRow} :
		                            {ctrl.gfxBank, bgIndex, vCount[2:0]};
		colourPipe <= vramData[7:3];
		if (planeLoad[0])
			bgColour <= colourPipe;	// Switches with the shifters
	end

	always_ff @(posedge CLK_6M or negedge RESET) begin
		if (!RESET)
			planeLoad <= '0;
		else
			planeLoad <= {NumPlanes{hCount[2:0] == loadPhase}};
	end

endmodule

//--- dv/arkVideoSva.sv
// Arkanoid video bound checks
// Blank gating of RGB and the vblank interrupt set and clear rules
`timescale 1ns/1ps

module arkVideoSva (
	input logic       CLK_6M,
	input logic       RESET,
	input logic [7:0] vgaR,
	input logic [7:0] vgaG,
	input logic [7:0] vgaB,
	input logic       vgaDe,
	input logic       cpuIrq,
	input logic       cpuIntAck,
	input logic [8:0] hCount,
	input logic [8:0] vCount
);

	// ========================================
	// Video output
	// ========================================
	blankRgbZero : assert property (@(posedge CLK_6M) disable iff (!RESET)
		!vgaDe |-> (vgaR == 8'd0 && vgaG == 8'd0 && vgaB == 8'd0))
		else $error("RGB not zero while display enable is low");

	// ========================================
	// Interrupt
	// ========================================
	irqSetPoint : assert property (@(posedge CLK_6M) disable iff (!RESET)
		$rose(cpuIrq) |-> ($past(hCount) == arkVideoPkg::IrqCol &&
		                   $past(vCount) == arkVideoPkg::IrqLine))
		else $error("Interrupt rose away from its raster point");

	irqHolds : assert property (@(posedge CLK_6M) disable iff (!RESET)
		(cpuIrq && !cpuIntAck) |=> cpuIrq)
		else $error("Interrupt dropped without an acknowledge");

	ackClears : assert property (@(posedge CLK_6M) disable iff (!RESET)
		cpuIntAck |=> !cpuIrq)
		else $error("Interrupt still high after acknowledge");

endmodule

bind arkVideoTop arkVideoSva i_arkVideoSva (
	.CLK_6M, .RESET, .vgaR, .vgaG, .vgaB, .vgaDe, .cpuIrq, .cpuIntAck,
	.hCount, .vCount
);

//--- dv/arkVideoTb.sv
// Arkanoid video testbench
// Drives the CPU bus, models tile and palette ROMs by rule, and watches
// sync timing, blanking, VRAM access, interrupt and sprite fetch
`timescale 1ns/1ps

module arkVideoTb;

	localparam int NumPlanes = 3;
	localparam int LineClocks = 384;
	localparam int FrameClocks = 264 * LineClocks;

	logic                        CLK_6M;
	logic                        RESET;
	logic [15:0]                 cpuAddr;
	logic [7:0]                  cpuDataOut;
	logic                        cpuWrN;
	logic                        cpuIntAck;
	logic [NumPlanes*8-1:0]      gfxRomData;
	arkVideoPkg::palEntry        palRomData;
	logic [7:0]                  cpuDataIn;
	logic                        cpuIrq;
	arkVideoPkg::gfxAddr         gfxRomAddr;
	arkVideoPkg::palAddr         palRomAddr;
	logic [7:0]                  vgaR;
	logic [7:0]                  vgaG;
	logic [7:0]                  vgaB;
	logic                        vgaHs;
	logic                        vgaVs;
	logic                        vgaDe;

	logic [31:0] lfsr = 32'h1257756a;
	int          testErrs [1:6];	// Indexed by test number
	int          hModel;	// Reference raster position
	int          vModel;
	int          hsFalls = 0;
	int          hsPeriod = 0;
	int          hsLow = 0;
	int          vsFalls = 0;
	int          vsPeriod = 0;
	int          vsLow = 0;
	int          irqRises = 0;
	logic        prevHs = 1'b1;
	logic        prevVs = 1'b1;
	logic        prevIrq = 1'b0;
	logic [2:0]  deHist = 3'b000;	// Expected enable, newest in bit 0
	arkVideoPkg::gfxAddr gfxAddrHeld = '0;	// ROM address of the previous cycle
	arkVideoPkg::palAddr palAddrHeld = '0;

	arkVideoTop #(.NumPlanes(NumPlanes)) i_arkVideoTop (
		.CLK_6M, .RESET, .cpuAddr, .cpuDataOut, .cpuWrN, .cpuIntAck, .gfxRomData,
		.palRomData, .cpuDataIn, .cpuIrq, .gfxRomAddr, .palRomAddr, .vgaR, .vgaG,
		.vgaB, .vgaHs, .vgaVs, .vgaDe
	);

	always #10 CLK_6M = !CLK_6M;	// 20 ns period

	// ========================================
	// ROM models with one cycle read latency
	// ========================================
	always @(negedge CLK_6M) begin
		for (int p = 0; p < NumPlanes; p++)
			gfxRomData[p*8 +: 8] <= gfxAddrHeld[7:0] ^ 8'(p);	// Plane byte rule
		palRomData  <= arkVideoPkg::palEntry'({3'd0, palAddrHeld});
		gfxAddrHeld <= gfxRomAddr;	// Answered in the next cycle
		palAddrHeld <= palRomAddr;
	end

	// Reference raster over H 128..511 and V 248..511
	always @(posedge CLK_6M or negedge RESET) begin
		if (!RESET) begin
			hModel <= 128;
			vModel <= 248;
		end else if (hModel == 511) begin
			hModel <= 128;
			vModel <= (vModel == 511) ? 248 : vModel + 1;
		end else begin
			hModel <= hModel + 1;
		end
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// Galois taps 32,22,2,1
	endfunction

	// Blank ranges H 140..256 and V 240..269
	function automatic logic rasterBlank(input int h, input int v);
		return (h >= 140 && h <= 256) || (v >= 240 && v <= 269);
	endfunction

	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	task automatic reportValue(input string name, input logic [31:0] got,
	                           input logic [31:0] exp, input int t);
		$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
		testErrs[t]++;
	endtask

	task automatic cpuWrite(input logic [15:0] addr, input logic [7:0] data);
		@(negedge CLK_6M);
		cpuAddr    = addr;
		cpuDataOut = data;
		cpuWrN     = 1'b0;
		@(negedge CLK_6M);
		cpuWrN  = 1'b1;
		cpuAddr = 16'h0000;	// Off the VRAM window
	endtask

	task automatic cpuRead(input logic [15:0] addr, output logic [7:0] data);
		@(negedge CLK_6M);
		cpuAddr = addr;
		@(negedge CLK_6M);
		data    = cpuDataIn;	// One cycle after the address
		cpuAddr = 16'h0000;
	endtask

	// Wait for a raised interrupt, check it holds, then acknowledge
	task automatic serviceIrq();
		while (!cpuIrq) @(negedge CLK_6M);
		repeat (4) begin
			@(negedge CLK_6M);
			assert (cpuIrq == 1'b1) else reportValue("cpuIrq", 32'(cpuIrq), 32'd1, 5);
		end
		cpuIntAck = 1'b1;
		@(negedge CLK_6M);
		cpuIntAck = 1'b0;
		assert (cpuIrq == 1'b0) else reportValue("cpuIrq", 32'(cpuIrq), 32'd0, 5);
	endtask

	task automatic printResult(input int t, input string name);
		$display("test %0d %s: %s, %0d errors", t, name,
		         (testErrs[t] == 0) ? "ok" : "FAILED", testErrs[t]);
	endtask

	// ========================================
	// Sync, blank and interrupt monitors
	// ========================================
	always @(negedge CLK_6M) begin
		if (RESET) begin
			hsPeriod++;
			vsPeriod++;
			if (!vgaHs) hsLow++;
			if (!vgaVs) vsLow++;
			if (prevHs && !vgaHs) begin
				if (hsFalls > 0)
					assert (hsPeriod == LineClocks)
						else reportValue("vgaHs period", 32'(hsPeriod), 32'(LineClocks), 1);
				hsFalls++;
				hsPeriod = 0;
			end
			if (!prevHs && vgaHs) begin
				assert (hsLow == 17) else reportValue("vgaHs low", 32'(hsLow), 32'd17, 1);
				hsLow = 0;
			end
			if (prevVs && !vgaVs) begin
				if (vsFalls > 0) begin
					assert (vsPeriod == FrameClocks)
						else reportValue("vgaVs period", 32'(vsPeriod), 32'(FrameClocks), 2);
					assert (irqRises == 1)
						else reportValue("cpuIrq rises", 32'(irqRises), 32'd1, 5);
				end
				vsFalls++;
				vsPeriod = 0;
				irqRises = 0;
			end
			if (!prevVs && vgaVs) begin
				assert (vsLow == 6 * LineClocks)
					else reportValue("vgaVs low", 32'(vsLow), 32'(6 * LineClocks), 2);
				vsLow = 0;
			end
			if (!prevIrq && cpuIrq) irqRises++;
			if (!vgaDe)
				assert ({vgaR, vgaG, vgaB} == 24'd0)
					else reportValue("vgaRGB", 32'({vgaR, vgaG, vgaB}), 32'd0, 3);
			// Enable trails the raster blank ranges by three clocks
			assert (vgaDe == deHist[2])
				else reportValue("vgaDe", 32'(vgaDe), 32'(deHist[2]), 3);
			deHist  = {deHist[1:0], !rasterBlank(hModel, vModel)};
			prevHs  = vgaHs;
			prevVs  = vgaVs;
			prevIrq = cpuIrq;
		end
	end

	// Watchdog after four frames of 20 ns clocks
	initial begin
		#(4 * FrameClocks * 20);
		$display("Watchdog expired before the tests completed");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		logic [7:0]  evenByte;
		logic [7:0]  oddByte;
		logic [7:0]  readByte;
		logic [9:0]  spriteIdx;
		logic [3:0]  spriteRow;
		logic [7:0]  spriteY;
		int          targetLine;
		logic        seen;
		int          total;

		CLK_6M     = 1'b0;
		RESET      = 1'b0;
		cpuAddr    = 16'h0000;
		cpuDataOut = 8'h00;
		cpuWrN     = 1'b1;
		cpuIntAck  = 1'b0;
		gfxRomData = '0;
		palRomData = '0;
		for (int t = 1; t <= 6; t++) testErrs[t] = 0;
		repeat (2) @(negedge CLK_6M);
		RESET = 1'b1;

		serviceIrq();	// First set lands just after reset

		// VRAM byte lanes at word 0x010
		randBits(8, rnd);
		evenByte = rnd[7:0];
		randBits(8, rnd);
		oddByte = rnd[7:0];
		cpuWrite(16'hE020, evenByte);
		cpuWrite(16'hE021, oddByte);
		cpuRead(16'hE020, readByte);
		assert (readByte == evenByte)
			else reportValue("cpuDataIn", 32'(readByte), 32'(evenByte), 4);
		cpuRead(16'hE021, readByte);
		assert (readByte == oddByte)
			else reportValue("cpuDataIn", 32'(readByte), 32'(oddByte), 4);
		printResult(4, "VRAM bytes");

		// Control register banks
		cpuWrite(arkVideoPkg::CtrlAddr, 8'h20);	// Gfx bank set, palette bank clear
		repeat (3) @(negedge CLK_6M);
		assert (gfxRomAddr[14] == 1'b1)
			else reportValue("gfxRomAddr[14]", 32'(gfxRomAddr[14]), 32'd1, 6);
		assert (palRomAddr[8] == 1'b0)
			else reportValue("palRomAddr[8]", 32'(palRomAddr[8]), 32'd0, 6);
		cpuWrite(arkVideoPkg::CtrlAddr, 8'h40);
		repeat (3) @(negedge CLK_6M);
		assert (gfxRomAddr[14] == 1'b0)
			else reportValue("gfxRomAddr[14]", 32'(gfxRomAddr[14]), 32'd0, 6);
		assert (palRomAddr[8] == 1'b1)
			else reportValue("palRomAddr[8]", 32'(palRomAddr[8]), 32'd1, 6);

		// Sprite slot 0 covering a line two ahead
		randBits(10, rnd);
		spriteIdx = rnd[9:0] | 10'h001;	// Nonzero keeps it apart from empty slots
		randBits(4, rnd);
		spriteRow = rnd[3:0];
		targetLine = (vModel + 2 > 511) ? vModel + 2 - 264 : vModel + 2;
		spriteY = 8'hF0 + {4'd0, spriteRow} - 8'(targetLine);	// Sum high nibble all ones
		cpuWrite(16'hE800, 8'h40);	// X
		cpuWrite(16'hE801, spriteY);
		cpuWrite(16'hE802, {1'b0, 5'd3, spriteIdx[9:8]});
		cpuWrite(16'hE803, spriteIdx[7:0]);
		seen = 1'b0;
		while (!(vModel == targetLine && hModel == 255)) begin
			@(negedge CLK_6M);
			if (vModel == targetLine && hModel >= 137 && hModel <= 255 &&
			    gfxRomAddr[13:0] == {spriteIdx, spriteRow})
				seen = 1'b1;
		end
		if (!seen) begin
			$display("Sprite fetch never addressed tile 0x%0h row 0x%0h", spriteIdx, spriteRow);
			testErrs[6]++;
		end
		printResult(6, "control register and sprite fetch");

		serviceIrq();	// Second frame
		while (vsFalls < 2) @(negedge CLK_6M);
		printResult(5, "interrupt");
		if (hsFalls < 2 || vsFalls < 2) begin
			$display("Too few sync edges seen to measure timing");
			testErrs[1]++;
		end
		printResult(1, "horizontal sync");
		printResult(2, "vertical sync");
		printResult(3, "blanking");

		total = 0;
		for (int t = 1; t <= 6; t++) total += testErrs[t];
		$display("tests 6, errors %0d", total);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- files.f
design/arkVideoPkg.sv
design/dualPortRam.sv
design/crtTiming.sv
design/cpuBusPort.sv
design/spriteFetch.sv
design/tileFetch.sv
design/bitplaneShifter.sv
design/pixelMixer.sv
design/arkVideoTop.sv
dv/arkVideoSva.sv
dv/arkVideoTb.sv
